/* debug_regs.sv */
//----------------------------------------------------------------------------
// dr6 status and dr7 control, updated on a debug exception; dr7 length
// fields are decoded into breakpoint address masks
//----------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module debug_regs (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  debug_start,
    input  wire                  bd_set,
    input  wire [3:0]            hit_code,
    input  wire [3:0]            hit_write,
    input  wire [3:0]            hit_read,
    input  wire                  hit_step,
    input  wire                  hit_task,
    input  wire [3:0]            dr6_breakpoints_next,
    input  wire                  dr6_b12_next,
    input  wire                  dr6_bd_next,
    input  wire                  dr6_bs_next,
    input  wire                  dr6_bt_next,
    input  wr_pkg::word_t        dr7_next,
    output logic [3:0]           dr6_breakpoints,
    output logic                 dr6_b12,
    output logic                 dr6_bd,
    output logic                 dr6_bs,
    output logic                 dr6_bt,
    output wr_pkg::word_t        dr7,
    output wr_pkg::debug_len_t   debug_len0,
    output wr_pkg::debug_len_t   debug_len1,
    output wr_pkg::debug_len_t   debug_len2,
    output wr_pkg::debug_len_t   debug_len3
);

    // len field 00 byte, 01 word, 11 dword, 10 undefined
    function automatic wr_pkg::debug_len_t decode_len(input logic [1:0] len);
        case (len)
            2'b00:   decode_len = 3'b111;
            2'b01:   decode_len = 3'b110;
            2'b10:   decode_len = 3'b000;
            default: decode_len = 3'b100;
        endcase
    endfunction

    //------------------------------------------------------------------------
    // dr6 / dr7
    //------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dr6_breakpoints <= 4'd0;
            dr6_b12         <= 1'b0;
            dr6_bs          <= 1'b0;
            dr6_bt          <= 1'b0;
            dr7             <= wr_pkg::startup_dr7;
        end else if (debug_start) begin
            dr6_breakpoints <= hit_code | hit_write | hit_read;
            dr6_b12         <= 1'b0;
            dr6_bs          <= hit_step;
            dr6_bt          <= hit_task;
            // GD drops so the handler can touch the debug registers
            dr7             <= dr7 & ~(32'd1 << wr_pkg::dr7_gd_bit);
        end else begin
            dr6_breakpoints <= dr6_breakpoints_next;
            dr6_b12         <= dr6_b12_next;
            dr6_bs          <= dr6_bs_next;
            dr6_bt          <= dr6_bt_next;
            dr7             <= dr7_next;
        end
    end

    // general-detect hit from execute
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dr6_bd <= 1'b0;
        end else if (bd_set) begin
            dr6_bd <= 1'b1;
        end else begin
            dr6_bd <= dr6_bd_next;
        end
    end

    assign debug_len0 = decode_len(dr7[wr_pkg::dr7_len_lsb0 +: 2]);
    assign debug_len1 = decode_len(dr7[wr_pkg::dr7_len_lsb1 +: 2]);
    assign debug_len2 = decode_len(dr7[wr_pkg::dr7_len_lsb2 +: 2]);
    assign debug_len3 = decode_len(dr7[wr_pkg::dr7_len_lsb3 +: 2]);

endmodule

`default_nettype wire

/* gpr_file.sv */
//----------------------------------------------------------------------------
// eight general registers; each cycle they load the execute-stage values
// unless a write-back or an esp restore overrides them
//----------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module gpr_file (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wr_pkg::reg_index_t       w_index,
    input  wr_pkg::operand_size_t    w_size,
    input  wire                      w_write,
    input  wr_pkg::word_t            result,
    input  wr_pkg::gpr_array_t       gpr_next,
    input  wire                      esp_restore,
    input  wr_pkg::word_t            esp_prev,
    output wr_pkg::gpr_array_t       gpr
);

    wr_pkg::gpr_array_t gpr_d;
    wr_pkg::word_t      merged;
    logic [2:0]         byte_reg;
    logic               esp_hit;

    // byte index 4..7 maps to ah/ch/dh/bh of the first four registers
    assign byte_reg = {1'b0, w_index[1:0]};

    // a byte write never lands in esp
    assign esp_hit = w_write && (w_size != wr_pkg::size_byte) &&
                     (w_index == wr_pkg::idx_esp);

    //------------------------------------------------------------------------
    // next value
    //------------------------------------------------------------------------
    always_comb begin
        gpr_d  = gpr_next;
        merged = gpr[w_index];
        if (w_write) begin
            case (w_size)
                wr_pkg::size_byte: begin
                    merged = gpr[byte_reg];
                    if (w_index[2]) begin
                        merged[15:8] = result[7:0];
                    end else begin
                        merged[7:0] = result[7:0];
                    end
                    gpr_d[byte_reg] = merged;
                end
                wr_pkg::size_word: begin
                    // esp upper half may already be updated by the stage
                    if (w_index == wr_pkg::idx_esp) begin
                        merged[31:16] = gpr_next[wr_pkg::idx_esp][31:16];
                    end
                    merged[15:0]   = result[15:0];
                    gpr_d[w_index] = merged;
                end
                default: begin
                    gpr_d[w_index] = result;
                end
            endcase
        end
        if (esp_restore && !esp_hit) begin
            gpr_d[wr_pkg::idx_esp] = esp_prev;
        end
    end

    //------------------------------------------------------------------------
    // storage
    //------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gpr <= {wr_pkg::gpr_count{wr_pkg::startup_gpr}};
        end else begin
            gpr <= gpr_d;
        end
    end

endmodule

`default_nettype wire

/* gpr_write_decode.sv */
//----------------------------------------------------------------------------
// decodes the write-back controls into target register, size and strobe
//----------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module gpr_write_decode (
    input  wire                      write_eax,
    input  wire                      write_regrm,
    input  wire                      dst_is_rm,
    input  wire                      dst_is_reg,
    input  wire                      dst_is_implicit_reg,
    input  wire [2:0]                modregrm_rm,
    input  wire [2:0]                modregrm_reg,
    input  wire [2:0]                implicit_reg,
    input  wire                      is_8bit,
    input  wire                      operand_32bit,
    input  wire                      regrm_word,
    input  wire                      regrm_dword,
    output wr_pkg::reg_index_t       w_index,
    output wr_pkg::operand_size_t    w_size,
    output logic                     w_write
);

    logic any_dst;

    assign any_dst = dst_is_rm || dst_is_reg || dst_is_implicit_reg;

    // write_eax alone needs no destination select
    assign w_write = write_eax || (write_regrm && any_dst);

    // destination select with rm first
    always_comb begin
        if (dst_is_rm) begin
            w_index = wr_pkg::reg_index_t'(modregrm_rm);
        end else if (dst_is_reg) begin
            w_index = wr_pkg::reg_index_t'(modregrm_reg);
        end else if (dst_is_implicit_reg) begin
            w_index = wr_pkg::reg_index_t'(implicit_reg);
        end else begin
            w_index = wr_pkg::idx_eax;
        end
    end

    // explicit word/dword overrides beat the operand-size attribute
    always_comb begin
        if (is_8bit) begin
            w_size = wr_pkg::size_byte;
        end else if (regrm_word) begin
            w_size = wr_pkg::size_word;
        end else if (regrm_dword) begin
            w_size = wr_pkg::size_dword;
        end else if (operand_32bit) begin
            w_size = wr_pkg::size_dword;
        end else begin
            w_size = wr_pkg::size_word;
        end
    end

endmodule

`default_nettype wire

/* mode_state.sv */
//----------------------------------------------------------------------------
// architectural bits behind the operating mode, with mode, cpl and the
// I/O permission check request derived from them
//----------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module mode_state (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         cr0_pe_next,
    input  wire         vmflag_next,
    input  wire [1:0]   iopl_next,
    input  wire [1:0]   cs_rpl_next,
    input  wire         rflag_next,
    input  wire         clear_rflag,
    input  wire         set_rflag,
    output logic        cr0_pe,
    output logic        vmflag,
    output logic [1:0]  iopl,
    output logic        rflag,
    output logic [1:0]  cpl,
    output logic        real_mode,
    output logic        protected_mode,
    output logic        v8086_mode,
    output logic        io_allow_check_needed
);

    logic [1:0] cs_rpl;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cr0_pe <= 1'b0;
            vmflag <= 1'b0;
            iopl   <= 2'd0;
            cs_rpl <= 2'd0;
        end else begin
            cr0_pe <= cr0_pe_next;
            vmflag <= vmflag_next;
            iopl   <= iopl_next;
            cs_rpl <= cs_rpl_next;
        end
    end

    // clear wins over the exception set
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rflag <= 1'b0;
        end else if (clear_rflag) begin
            rflag <= 1'b0;
        end else if (set_rflag) begin
            rflag <= 1'b1;
        end else begin
            rflag <= rflag_next;
        end
    end

    //------------------------------------------------------------------------
    // derived mode
    //------------------------------------------------------------------------
    assign cpl            = cs_rpl;
    assign real_mode      = !cr0_pe;
    assign protected_mode = cr0_pe && !vmflag;
    assign v8086_mode     = cr0_pe && vmflag;

    // v86 always checks, protected mode only when cpl is above iopl
    assign io_allow_check_needed = cr0_pe && (vmflag || (cpl > iopl));

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert --top-module tb_write_register -f src.f \
        -o sim_write_register; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_write_register 2>&1)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "test passed"; then
    exit 0
fi
exit 1

/* src.f */
wr_pkg.sv
gpr_write_decode.sv
gpr_file.sv
mode_state.sv
debug_regs.sv
write_register.sv
tb_write_register.sv

/* tb_write_register.sv */
//----------------------------------------------------------------------------
// testbench for the write-back register stage; replays the case file one
// cycle per line and compares every output after the rising edge
//----------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_write_register;

    localparam int half_period    = 50;
    localparam int reset_cycles   = 3;
    localparam int timeout_margin = 20;

    logic                 clk;
    logic                 rst_n;
    // write-back
    logic                 write_eax;
    logic                 write_regrm;
    logic                 dst_is_rm;
    logic                 dst_is_reg;
    logic                 dst_is_implicit_reg;
    logic [2:0]           modregrm_rm;
    logic [2:0]           modregrm_reg;
    logic [2:0]           implicit_reg;
    logic                 is_8bit;
    logic                 operand_32bit;
    logic                 regrm_word;
    logic                 regrm_dword;
    wr_pkg::word_t        result;
    wr_pkg::gpr_array_t   gpr_next;
    logic                 esp_restore;
    wr_pkg::word_t        esp_prev;
    // mode
    logic                 cr0_pe_next;
    logic                 vmflag_next;
    logic [1:0]           iopl_next;
    logic [1:0]           cs_rpl_next;
    logic                 rflag_next;
    logic                 clear_rflag;
    logic                 set_rflag;
    // debug
    logic                 debug_start;
    logic                 bd_set;
    logic [3:0]           hit_code;
    logic [3:0]           hit_write;
    logic [3:0]           hit_read;
    logic                 hit_step;
    logic                 hit_task;
    logic [3:0]           dr6_breakpoints_next;
    logic                 dr6_b12_next;
    logic                 dr6_bd_next;
    logic                 dr6_bs_next;
    logic                 dr6_bt_next;
    wr_pkg::word_t        dr7_next;
    // DUT outputs
    wr_pkg::gpr_array_t   gpr;
    logic                 cr0_pe;
    logic                 vmflag;
    logic [1:0]           iopl;
    logic                 rflag;
    logic [1:0]           cpl;
    logic                 real_mode;
    logic                 protected_mode;
    logic                 v8086_mode;
    logic                 io_allow_check_needed;
    logic [3:0]           dr6_breakpoints;
    logic                 dr6_b12;
    logic                 dr6_bd;
    logic                 dr6_bs;
    logic                 dr6_bt;
    wr_pkg::word_t        dr7;
    wr_pkg::debug_len_t   debug_len0;
    wr_pkg::debug_len_t   debug_len1;
    wr_pkg::debug_len_t   debug_len2;
    wr_pkg::debug_len_t   debug_len3;

    string                case_lines[$];
    int                   cur_case;
    int                   cycle_count;
    int                   cycle_limit;
    // expectation of the case in flight
    logic [31:0]          case_base;
    int                   exp_index;
    logic [31:0]          exp_value;
    logic [10:0]          exp_mode;
    logic [7:0]           exp_dr6;
    logic [31:0]          exp_dr7;
    logic [11:0]          exp_len;

    write_register write_register_inst (.*);

    always #half_period clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            abort_run($sformatf("run timed out after %0d cycles", cycle_count));
        end
    end

    //------------------------------------------------------------------------
    // helpers
    //------------------------------------------------------------------------
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            abort_run($sformatf("Mismatch %s in case %0d: expected %h, got %h",
                                name, cur_case, expected, actual));
        end
    endtask

    // per-register value offered by the execute stage
    function automatic logic [31:0] next_pattern(input logic [31:0] base, input int idx);
        return base ^ (32'h1111_1111 * idx);
    endfunction

    task automatic load_cases();
        int    fd;
        int    code;
        string line;
        fd = $fopen("write_register_cases.txt", "r");
        if (fd == 0) begin
            abort_run("could not open write_register_cases.txt");
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            // comment and blank lines
            if (code > 0 && line.len() > 8 && line[0] != "#") begin
                case_lines.push_back(line);
            end
        end
        $fclose(fd);
        if (case_lines.size() == 0) begin
            abort_run("the case file holds no cases");
        end
    endtask

    // ctl  = {write_eax, write_regrm, dst_is_rm, dst_is_reg, dst_is_implicit_reg,
    //         is_8bit, operand_32bit, regrm_word, regrm_dword, esp_restore}
    // sel  = {rm, reg, implicit} one hex digit each
    // mode = {pe, vm, iopl, cs_rpl, rflag_next, clear_rflag, set_rflag}
    // dbg  = {debug_start, bd_set, hit_step, hit_task, b12, bd, bs, bt next}
    // hits = {hit_code, hit_write, hit_read, dr6_breakpoints_next}
    task automatic apply_case(input string line);
        logic [9:0]  ctl;
        logic [11:0] sel;
        logic [8:0]  mode_in;
        logic [7:0]  dbg_in;
        logic [15:0] hits;
        int          fields;
        fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %o",
                         ctl, sel, result, case_base, esp_prev, mode_in, dbg_in, hits,
                         dr7_next, exp_index, exp_value, exp_mode, exp_dr6, exp_dr7,
                         exp_len);
        if (fields != 15) begin
            abort_run($sformatf("case %0d has %0d fields instead of 15", cur_case, fields));
        end
        {write_eax, write_regrm, dst_is_rm, dst_is_reg, dst_is_implicit_reg,
         is_8bit, operand_32bit, regrm_word, regrm_dword, esp_restore} = ctl;
        modregrm_rm  = sel[10:8];
        modregrm_reg = sel[6:4];
        implicit_reg = sel[2:0];
        for (int i = 0; i < 8; i++) begin
            gpr_next[i[2:0]] = next_pattern(case_base, i);
        end
        {cr0_pe_next, vmflag_next, iopl_next, cs_rpl_next,
         rflag_next, clear_rflag, set_rflag} = mode_in;
        {debug_start, bd_set, hit_step, hit_task,
         dr6_b12_next, dr6_bd_next, dr6_bs_next, dr6_bt_next} = dbg_in;
        {hit_code, hit_write, hit_read, dr6_breakpoints_next} = hits;
    endtask

    task automatic check_reset();
        for (int i = 0; i < 8; i++) begin
            check_value($sformatf("gpr[%0d]", i), 32'h0, gpr[i[2:0]]);
        end
        check_value("dr7", 32'h0000_0400, dr7);
        check_value("dr6_breakpoints", 32'h0, 32'(dr6_breakpoints));
        check_value("real_mode", 32'h1, 32'(real_mode));
        check_value("io_allow_check_needed", 32'h0, 32'(io_allow_check_needed));
        check_value("debug_len0", 32'h7, 32'(debug_len0));
        check_value("debug_len1", 32'h7, 32'(debug_len1));
        check_value("debug_len2", 32'h7, 32'(debug_len2));
        check_value("debug_len3", 32'h7, 32'(debug_len3));
    endtask

    task automatic check_case();
        logic [31:0] expected;
        for (int i = 0; i < 8; i++) begin
            expected = (i == exp_index) ? exp_value : next_pattern(case_base, i);
            check_value($sformatf("gpr[%0d]", i), expected, gpr[i[2:0]]);
        end
        check_value("cr0_pe", 32'(exp_mode[10]), 32'(cr0_pe));
        check_value("vmflag", 32'(exp_mode[9]), 32'(vmflag));
        check_value("iopl", 32'(exp_mode[8:7]), 32'(iopl));
        check_value("rflag", 32'(exp_mode[6]), 32'(rflag));
        check_value("cpl", 32'(exp_mode[5:4]), 32'(cpl));
        check_value("real_mode", 32'(exp_mode[3]), 32'(real_mode));
        check_value("protected_mode", 32'(exp_mode[2]), 32'(protected_mode));
        check_value("v8086_mode", 32'(exp_mode[1]), 32'(v8086_mode));
        check_value("io_allow_check_needed", 32'(exp_mode[0]), 32'(io_allow_check_needed));
        check_value("dr6_breakpoints", 32'(exp_dr6[7:4]), 32'(dr6_breakpoints));
        check_value("dr6_b12", 32'(exp_dr6[3]), 32'(dr6_b12));
        check_value("dr6_bd", 32'(exp_dr6[2]), 32'(dr6_bd));
        check_value("dr6_bs", 32'(exp_dr6[1]), 32'(dr6_bs));
        check_value("dr6_bt", 32'(exp_dr6[0]), 32'(dr6_bt));
        check_value("dr7", exp_dr7, dr7);
        check_value("debug_len0", 32'(exp_len[2:0]), 32'(debug_len0));
        check_value("debug_len1", 32'(exp_len[5:3]), 32'(debug_len1));
        check_value("debug_len2", 32'(exp_len[8:6]), 32'(debug_len2));
        check_value("debug_len3", 32'(exp_len[11:9]), 32'(debug_len3));
    endtask

    //------------------------------------------------------------------------
    // main sequence
    //------------------------------------------------------------------------
    initial begin
        clk                  = 1'b0;
        rst_n                = 1'b0;
        write_eax            = 1'b0;
        write_regrm          = 1'b0;
        dst_is_rm            = 1'b0;
        dst_is_reg           = 1'b0;
        dst_is_implicit_reg  = 1'b0;
        modregrm_rm          = 3'd0;
        modregrm_reg         = 3'd0;
        implicit_reg         = 3'd0;
        is_8bit              = 1'b0;
        operand_32bit        = 1'b0;
        regrm_word           = 1'b0;
        regrm_dword          = 1'b0;
        result               = '0;
        gpr_next             = '0;
        esp_restore          = 1'b0;
        esp_prev             = '0;
        cr0_pe_next          = 1'b0;
        vmflag_next          = 1'b0;
        iopl_next            = 2'd0;
        cs_rpl_next          = 2'd0;
        rflag_next           = 1'b0;
        clear_rflag          = 1'b0;
        set_rflag            = 1'b0;
        debug_start          = 1'b0;
        bd_set               = 1'b0;
        hit_code             = 4'd0;
        hit_write            = 4'd0;
        hit_read             = 4'd0;
        hit_step             = 1'b0;
        hit_task             = 1'b0;
        dr6_breakpoints_next = 4'd0;
        dr6_b12_next         = 1'b0;
        dr6_bd_next          = 1'b0;
        dr6_bs_next          = 1'b0;
        dr6_bt_next          = 1'b0;
        dr7_next             = 32'h0000_0400;
        cur_case             = 0;
        cycle_count          = 0;
        cycle_limit          = reset_cycles + timeout_margin;

        load_cases();
        cycle_limit = case_lines.size() + reset_cycles + timeout_margin;

        repeat (reset_cycles) @(negedge clk);
        check_reset();
        rst_n = 1'b1;

        // one case per cycle, checked at the next falling edge
        foreach (case_lines[n]) begin
            cur_case = n + 1;
            apply_case(case_lines[n]);
            @(negedge clk);
            check_case();
        end

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* wr_pkg.sv */
//----------------------------------------------------------------------------
// shared types and constants of the write-back register stage
// referenced by scoped name from every RTL block
//----------------------------------------------------------------------------
`default_nettype none

package wr_pkg;

    //------------------------------------------------------------------------
    // widths
    //------------------------------------------------------------------------
    localparam int word_w    = 32;
    localparam int gpr_count = 8;

    typedef logic [word_w-1:0] word_t;

    // eight registers in reg_index_t order
    typedef word_t [gpr_count-1:0] gpr_array_t;

    // x86 register encoding as used in modrm
    typedef enum logic [2:0] {
        idx_eax = 3'd0,
        idx_ecx = 3'd1,
        idx_edx = 3'd2,
        idx_ebx = 3'd3,
        idx_esp = 3'd4,
        idx_ebp = 3'd5,
        idx_esi = 3'd6,
        idx_edi = 3'd7
    } reg_index_t;

    typedef enum logic [1:0] {
        size_byte,
        size_word,
        size_dword
    } operand_size_t;

    //------------------------------------------------------------------------
    // startup values
    //------------------------------------------------------------------------
    localparam word_t startup_gpr = 32'h0000_0000;
    localparam word_t startup_dr7 = 32'h0000_0400;

    // dr7 field positions
    localparam int dr7_gd_bit   = 13;
    localparam int dr7_len_lsb0 = 18;
    localparam int dr7_len_lsb1 = 22;
    localparam int dr7_len_lsb2 = 26;
    localparam int dr7_len_lsb3 = 30;

    // address mask for a breakpoint of the given length
    typedef logic [2:0] debug_len_t;

endpackage

`default_nettype wire

/* write_register.sv */
//----------------------------------------------------------------------------
// write-back register stage top: general registers, mode state and
// debug registers, fed directly from the execute and exception logic
//----------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module write_register (
    input  wire                  clk,
    input  wire                  rst_n,
    // write-back control
    input  wire                  write_eax,
    input  wire                  write_regrm,
    input  wire                  dst_is_rm,
    input  wire                  dst_is_reg,
    input  wire                  dst_is_implicit_reg,
    input  wire [2:0]            modregrm_rm,
    input  wire [2:0]            modregrm_reg,
    input  wire [2:0]            implicit_reg,
    input  wire                  is_8bit,
    input  wire                  operand_32bit,
    input  wire                  regrm_word,
    input  wire                  regrm_dword,
    input  wr_pkg::word_t        result,
    input  wr_pkg::gpr_array_t   gpr_next,
    input  wire                  esp_restore,
    input  wr_pkg::word_t        esp_prev,
    // mode
    input  wire                  cr0_pe_next,
    input  wire                  vmflag_next,
    input  wire [1:0]            iopl_next,
    input  wire [1:0]            cs_rpl_next,
    input  wire                  rflag_next,
    input  wire                  clear_rflag,
    input  wire                  set_rflag,
    // debug
    input  wire                  debug_start,
    input  wire                  bd_set,
    input  wire [3:0]            hit_code,
    input  wire [3:0]            hit_write,
    input  wire [3:0]            hit_read,
    input  wire                  hit_step,
    input  wire                  hit_task,
    input  wire [3:0]            dr6_breakpoints_next,
    input  wire                  dr6_b12_next,
    input  wire                  dr6_bd_next,
    input  wire                  dr6_bs_next,
    input  wire                  dr6_bt_next,
    input  wr_pkg::word_t        dr7_next,
    // outputs
    output wr_pkg::gpr_array_t   gpr,
    output logic                 cr0_pe,
    output logic                 vmflag,
    output logic [1:0]           iopl,
    output logic                 rflag,
    output logic [1:0]           cpl,
    output logic                 real_mode,
    output logic                 protected_mode,
    output logic                 v8086_mode,
    output logic                 io_allow_check_needed,
    output logic [3:0]           dr6_breakpoints,
    output logic                 dr6_b12,
    output logic                 dr6_bd,
    output logic                 dr6_bs,
    output logic                 dr6_bt,
    output wr_pkg::word_t        dr7,
    output wr_pkg::debug_len_t   debug_len0,
    output wr_pkg::debug_len_t   debug_len1,
    output wr_pkg::debug_len_t   debug_len2,
    output wr_pkg::debug_len_t   debug_len3
);

    wr_pkg::reg_index_t    w_index;
    wr_pkg::operand_size_t w_size;
    logic                  w_write;

    gpr_write_decode gpr_write_decode_inst (
        .write_eax           (write_eax),
        .write_regrm         (write_regrm),
        .dst_is_rm           (dst_is_rm),
        .dst_is_reg          (dst_is_reg),
        .dst_is_implicit_reg (dst_is_implicit_reg),
        .modregrm_rm         (modregrm_rm),
        .modregrm_reg        (modregrm_reg),
        .implicit_reg        (implicit_reg),
        .is_8bit             (is_8bit),
        .operand_32bit       (operand_32bit),
        .regrm_word          (regrm_word),
        .regrm_dword         (regrm_dword),
        .w_index             (w_index),
        .w_size              (w_size),
        .w_write             (w_write)
    );

    gpr_file gpr_file_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .w_index     (w_index),
        .w_size      (w_size),
        .w_write     (w_write),
        .result      (result),
        .gpr_next    (gpr_next),
        .esp_restore (esp_restore),
        .esp_prev    (esp_prev),
        .gpr         (gpr)
    );

    mode_state mode_state_inst (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .cr0_pe_next           (cr0_pe_next),
        .vmflag_next           (vmflag_next),
        .iopl_next             (iopl_next),
        .cs_rpl_next           (cs_rpl_next),
        .rflag_next            (rflag_next),
        .clear_rflag           (clear_rflag),
        .set_rflag             (set_rflag),
        .cr0_pe                (cr0_pe),
        .vmflag                (vmflag),
        .iopl                  (iopl),
        .rflag                 (rflag),
        .cpl                   (cpl),
        .real_mode             (real_mode),
        .protected_mode        (protected_mode),
        .v8086_mode            (v8086_mode),
        .io_allow_check_needed (io_allow_check_needed)
    );

    debug_regs debug_regs_inst (
        .clk                  (clk),
        .rst_n                (rst_n),
        .debug_start          (debug_start),
        .bd_set               (bd_set),
        .hit_code             (hit_code),
        .hit_write            (hit_write),
        .hit_read             (hit_read),
        .hit_step             (hit_step),
        .hit_task             (hit_task),
        .dr6_breakpoints_next (dr6_breakpoints_next),
        .dr6_b12_next         (dr6_b12_next),
        .dr6_bd_next          (dr6_bd_next),
        .dr6_bs_next          (dr6_bs_next),
        .dr6_bt_next          (dr6_bt_next),
        .dr7_next             (dr7_next),
        .dr6_breakpoints      (dr6_breakpoints),
        .dr6_b12              (dr6_b12),
        .dr6_bd               (dr6_bd),
        .dr6_bs               (dr6_bs),
        .dr6_bt               (dr6_bt),
        .dr7                  (dr7),
        .debug_len0           (debug_len0),
        .debug_len1           (debug_len1),
        .debug_len2           (debug_len2),
        .debug_len3           (debug_len3)
    );

endmodule

`default_nettype wire

/* write_register_cases.txt */
# in: ctl sel result nb esp_prev mode dbg hits dr7_next  out: idx value mode dr6 dr7 len(octal)
# gpr_next[i] = nb ^ i*11111111; every gpr except idx expects that value
000 000 00000000 00000000 00000000 000 00 0000 00000400 8 00000000 008 00 00000400 7777
000 000 00000000 a0b0c0d0 00000000 000 00 0000 00000400 8 00000000 008 00 00000400 7777
210 000 0000005a 01020304 00000000 000 00 0000 00000400 0 a0b0c05a 008 00 00000400 7777
150 740 123456c3 00000000 00000000 000 00 0000 00000400 0 a0b0c35a 008 00 00000400 7777
1c0 350 deadbeef ffff0000 00000000 000 00 0000 00000400 3 3333beef 008 00 00000400 7777
12c 004 0000cafe 12345678 00000000 000 00 0000 00000400 4 5670cafe 008 00 00000400 7777
122 006 87654321 00000000 00000000 000 00 0000 00000400 6 87654321 008 00 00000400 7777
20e 000 ffff1234 55550000 00000000 000 00 0000 00000400 0 00001234 008 00 00000400 7777
001 000 00000000 00000000 0badf00d 000 00 0000 00000400 4 0badf00d 008 00 00000400 7777
149 040 11223344 00000000 0badf00d 000 00 0000 00000400 4 11223344 008 00 00000400 7777
108 000 deadbeef 13579bdf 00000000 000 00 0000 00000400 8 00000000 008 00 00000400 7777
000 000 00000000 00000000 00000000 17c 00 0000 00000400 8 00000000 5f4 00 00000400 7777
000 000 00000000 00000000 00000000 131 00 0000 00000400 8 00000000 4e5 00 00000400 7777
000 000 00000000 00000000 00000000 1e7 00 0000 00000400 8 00000000 783 00 00000400 7777
000 000 00000000 00000000 00000000 098 00 0000 00000400 8 00000000 238 00 00000400 7777
000 000 00000000 00000000 00000000 000 0a 0005 c8402400 8 00000000 008 5a c8402400 4067
000 000 00000000 00000000 00000000 000 a9 1280 00000400 8 00000000 008 b2 c8400400 4067
000 000 00000000 00000000 00000000 000 41 0000 000c0400 8 00000000 008 05 000c0400 7774
000 000 00000000 00000000 00000000 000 d0 0400 00000400 8 00000000 008 45 000c0400 7774
000 000 00000000 00000000 00000000 000 00 0000 00000400 8 00000000 008 00 00000400 7777
